// ==== hw/lc3Pkg.sv ====
`default_nettype none

package lc3Pkg;

	// Data path and register index widths fixed by the LC-3
	localparam int wordWidth = 16;
	localparam int regAddrWidth = 3;

	// One-hot NZP code, N is bit 2, Z bit 1, P bit 0
	localparam int ccWidth = 3;

	// Opcodes of the arithmetic subset, bits 15:12 of the instruction
	typedef enum logic [3:0] {
		opAdd = 4'b0001,
		opAnd = 4'b0101,
		opNot = 4'b1001
	} lc3Opcode;

	// Operation carried from decode into the execute stage
	typedef enum logic [1:0] {
		aluAdd = 2'd0,
		aluAnd = 2'd1,
		aluNot = 2'd2,
		aluNone = 2'd3	// illegal opcode, no result
	} aluOp;

endpackage

`default_nettype wire

// ==== hw/lc3RegFile.sv ====
`default_nettype none

module lc3RegFile
	import lc3Pkg::*;
(
	input logic Clk,
	input logic rst,

	// Operand reads for the decode stage
	input logic [regAddrWidth-1:0] rdAddrA,
	input logic [regAddrWidth-1:0] rdAddrB,
	output logic [wordWidth-1:0] rdDataA,
	output logic [wordWidth-1:0] rdDataB,

	// Write-back from the result stage
	input logic wrEnable,
	input logic [regAddrWidth-1:0] wrAddr,
	input logic [wordWidth-1:0] wrData
);

	localparam int regCount = 2 ** regAddrWidth;

	logic [wordWidth-1:0] regs [regCount];

	// Reset clears R0 to R7, a write lands on the edge
	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEnable) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Reads see the array as it stands, so a write shows up next cycle
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

// ==== hw/lc3Decode.sv ====
`default_nettype none

module lc3Decode
	import lc3Pkg::*;
(
	input logic Clk,
	input logic rst,

	// Instruction input
	input logic inValid,
	output logic inReady,
	input logic [wordWidth-1:0] inInstr,

	// Register file read ports
	output logic [regAddrWidth-1:0] rdAddrA,
	output logic [regAddrWidth-1:0] rdAddrB,
	input logic [wordWidth-1:0] rdDataA,
	input logic [wordWidth-1:0] rdDataB,

	// Decode stage register towards execute
	output logic decValid,
	input logic decReady,
	output aluOp decOp,
	output logic [wordWidth-1:0] decA,
	output logic [wordWidth-1:0] decB,
	output logic [regAddrWidth-1:0] decDest,
	output logic decIllegal,

	// Write-back pulse, clears the pending bit
	input logic wrEnable,
	input logic [regAddrWidth-1:0] wrAddr
);

	localparam int regCount = 2 ** regAddrWidth;

	logic [3:0] opField;
	logic [regAddrWidth-1:0] dest;
	logic [regAddrWidth-1:0] sr1;
	logic [regAddrWidth-1:0] sr2;
	logic immMode;
	logic [wordWidth-1:0] immExt;
	aluOp op;
	logic legal;
	logic useSr2;
	logic hazard;
	logic accept;
	logic [regCount-1:0] pending;
	logic [regCount-1:0] setMask;
	logic [regCount-1:0] clearMask;

	// Instruction fields
	assign opField = inInstr[15:12];
	assign dest = inInstr[11:9];
	assign sr1 = inInstr[8:6];
	assign immMode = inInstr[5];
	assign sr2 = inInstr[2:0];
	assign immExt = {{(wordWidth - 5){inInstr[4]}}, inInstr[4:0]};

	always_comb begin
		case (opField)
			opAdd: op = aluAdd;
			opAnd: op = aluAnd;
			opNot: op = aluNot;
			default: op = aluNone;
		endcase
	end

	assign legal = (op != aluNone);
	// NOT and the immediate forms read only SR1
	assign useSr2 = (op == aluAdd || op == aluAnd) && !immMode;

	assign rdAddrA = sr1;
	assign rdAddrB = sr2;

	// Wait on pending sources; a pending destination also holds issue,
	// otherwise an older write-back would clear the newer claim
	assign hazard = legal && (pending[sr1] || (useSr2 && pending[sr2]) || pending[dest]);

	assign inReady = !hazard && (!decValid || decReady);
	assign accept = inValid && inReady;

	// Scoreboard, a set on the same edge as a clear wins
	always_comb begin
		setMask = '0;
		clearMask = '0;
		if (accept && legal) begin
			setMask[dest] = 1'b1;
		end
		if (wrEnable) begin
			clearMask[wrAddr] = 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~clearMask) | setMask;
		end
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			decValid <= 1'b0;
		end else if (accept) begin
			decValid <= 1'b1;
		end else if (decReady) begin
			decValid <= 1'b0;
		end
	end

	always_ff @(posedge Clk) begin
		if (accept) begin
			decOp <= op;
			decA <= rdDataA;
			decB <= immMode ? immExt : rdDataB;
			decDest <= dest;
			decIllegal <= !legal;
		end
	end

endmodule

`default_nettype wire

// ==== hw/lc3Execute.sv ====
`default_nettype none

module lc3Execute
	import lc3Pkg::*;
(
	input logic Clk,
	input logic rst,

	// From the decode stage
	input logic decValid,
	output logic decReady,
	input aluOp decOp,
	input logic [wordWidth-1:0] decA,
	input logic [wordWidth-1:0] decB,
	input logic [regAddrWidth-1:0] decDest,
	input logic decIllegal,

	// Execute stage register towards result
	output logic exeValid,
	input logic exeReady,
	output logic [wordWidth-1:0] exeData,
	output logic [regAddrWidth-1:0] exeDest,
	output logic exeIllegal
);

	logic [wordWidth-1:0] aluResult;
	logic load;

	// ALU, the add wraps at 16 bits
	always_comb begin
		case (decOp)
			aluAdd: aluResult = decA + decB;
			aluAnd: aluResult = decA & decB;
			aluNot: aluResult = ~decA;
			default: aluResult = '0;
		endcase
	end

	// Load when empty or when the held result leaves this edge
	assign decReady = !exeValid || exeReady;
	assign load = decValid && decReady;

	always_ff @(posedge Clk) begin
		if (rst) begin
			exeValid <= 1'b0;
		end else if (load) begin
			exeValid <= 1'b1;
		end else if (exeReady) begin
			exeValid <= 1'b0;
		end
	end

	always_ff @(posedge Clk) begin
		if (load) begin
			exeData <= aluResult;
			exeDest <= decDest;
			exeIllegal <= decIllegal;
		end
	end

endmodule

`default_nettype wire

// ==== hw/lc3Result.sv ====
`default_nettype none

module lc3Result
	import lc3Pkg::*;
(
	input logic Clk,
	input logic rst,

	// From the execute stage
	input logic exeValid,
	output logic exeReady,
	input logic [wordWidth-1:0] exeData,
	input logic [regAddrWidth-1:0] exeDest,
	input logic exeIllegal,

	// Output port
	output logic outValid,
	input logic outReady,
	output logic [wordWidth-1:0] outData,
	output logic [regAddrWidth-1:0] outDest,
	output logic [ccWidth-1:0] outCc,
	output logic outIllegal,

	// Register write-back
	output logic wrEnable,
	output logic [regAddrWidth-1:0] wrAddr,
	output logic [wordWidth-1:0] wrData
);

	logic [ccWidth-1:0] cc;
	logic load;

	// NZP of the incoming data, zero for an illegal result
	always_comb begin
		if (exeIllegal) begin
			cc = 3'b000;
		end else if (exeData[wordWidth-1]) begin
			cc = 3'b100;
		end else if (exeData == '0) begin
			cc = 3'b010;
		end else begin
			cc = 3'b001;
		end
	end

	assign exeReady = !outValid || outReady;
	assign load = exeValid && exeReady;

	always_ff @(posedge Clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (load) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	always_ff @(posedge Clk) begin
		if (load) begin
			outData <= exeData;
			outDest <= exeDest;
			outCc <= cc;
			outIllegal <= exeIllegal;
		end
	end

	// Architectural write happens only as a legal result is taken
	assign wrEnable = outValid && outReady && !outIllegal;
	assign wrAddr = outDest;
	assign wrData = outData;

endmodule

`default_nettype wire

// ==== hw/lc3AluCore.sv ====
`default_nettype none

module lc3AluCore
	import lc3Pkg::*;
(
	input logic Clk,
	input logic rst,

	input logic inValid,
	output logic inReady,
	input logic [wordWidth-1:0] inInstr,

	output logic outValid,
	input logic outReady,
	output logic [wordWidth-1:0] outData,
	output logic [regAddrWidth-1:0] outDest,
	output logic [ccWidth-1:0] outCc,
	output logic outIllegal
);

	// Register file reads
	logic [regAddrWidth-1:0] rdAddrA;
	logic [regAddrWidth-1:0] rdAddrB;
	logic [wordWidth-1:0] rdDataA;
	logic [wordWidth-1:0] rdDataB;

	// Decode to execute
	logic decValid;
	logic decReady;
	aluOp decOp;
	logic [wordWidth-1:0] decA;
	logic [wordWidth-1:0] decB;
	logic [regAddrWidth-1:0] decDest;
	logic decIllegal;

	// Execute to result
	logic exeValid;
	logic exeReady;
	logic [wordWidth-1:0] exeData;
	logic [regAddrWidth-1:0] exeDest;
	logic exeIllegal;

	// Write-back, also feeds the scoreboard
	logic wrEnable;
	logic [regAddrWidth-1:0] wrAddr;
	logic [wordWidth-1:0] wrData;

	lc3Decode decode (
		.Clk(Clk), .rst(rst),
		.inValid(inValid), .inReady(inReady), .inInstr(inInstr),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.decValid(decValid), .decReady(decReady), .decOp(decOp), .decA(decA),
		.decB(decB), .decDest(decDest), .decIllegal(decIllegal),
		.wrEnable(wrEnable), .wrAddr(wrAddr)
	);

	lc3RegFile regFile (
		.Clk(Clk), .rst(rst),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrEnable(wrEnable), .wrAddr(wrAddr), .wrData(wrData)
	);

	lc3Execute execute (
		.Clk(Clk), .rst(rst),
		.decValid(decValid), .decReady(decReady), .decOp(decOp), .decA(decA),
		.decB(decB), .decDest(decDest), .decIllegal(decIllegal),
		.exeValid(exeValid), .exeReady(exeReady), .exeData(exeData),
		.exeDest(exeDest), .exeIllegal(exeIllegal)
	);

	lc3Result result (
		.Clk(Clk), .rst(rst),
		.exeValid(exeValid), .exeReady(exeReady), .exeData(exeData),
		.exeDest(exeDest), .exeIllegal(exeIllegal),
		.outValid(outValid), .outReady(outReady), .outData(outData),
		.outDest(outDest), .outCc(outCc), .outIllegal(outIllegal),
		.wrEnable(wrEnable), .wrAddr(wrAddr), .wrData(wrData)
	);

endmodule

`default_nettype wire

// ==== bench/benchClock.sv ====
`default_nettype none

module benchClock (
	output logic Clk,
	output logic rst
);

	localparam int halfPeriod = 5;
	localparam int resetCycles = 8;

	initial begin
		Clk = 1'b0;
		forever #halfPeriod Clk = ~Clk;
	end

	// Reset drops on a rising edge after eight cycles
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge Clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== bench/lc3AluCoreBench.sv ====
`default_nettype none

module lc3AluCoreBench
	import lc3Pkg::*;
();

	// About 400 instructions at up to 20 cycles each, with margin
	localparam int cycleLimit = 20000;

	// Expected output as {illegal, nzp, dest, data}
	typedef logic [ccWidth+regAddrWidth+wordWidth:0] resultWord;

	logic Clk;
	logic rst;
	logic inValid;
	logic inReady;
	logic [wordWidth-1:0] inInstr;
	logic outValid;
	logic outReady;
	logic [wordWidth-1:0] outData;
	logic [regAddrWidth-1:0] outDest;
	logic [ccWidth-1:0] outCc;
	logic outIllegal;

	resultWord expQ[$];
	resultWord expHead;
	logic haveExp;
	logic [wordWidth-1:0] predRegs [8];
	logic outFire;
	logic latencyOn;
	logic latAccept;
	logic randomReady;
	logic [31:0] rng;
	int cycles = 0;
	string testName;

	benchClock clockGen (.Clk(Clk), .rst(rst));

	lc3AluCore DUT (
		.Clk(Clk), .rst(rst),
		.inValid(inValid), .inReady(inReady), .inInstr(inInstr),
		.outValid(outValid), .outReady(outReady), .outData(outData),
		.outDest(outDest), .outCc(outCc), .outIllegal(outIllegal)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [wordWidth-1:0] regForm(input lc3Opcode op, input int dr,
			input int sr1, input int sr2);
		return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
	endfunction

	function automatic logic [wordWidth-1:0] immForm(input lc3Opcode op, input int dr,
			input int sr1, input int imm);
		return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
	endfunction

	function automatic logic [wordWidth-1:0] notForm(input int dr, input int sr);
		return {opNot, 3'(dr), 3'(sr), 6'b111111};
	endfunction

	// Opcodes ending in 10 are never arithmetic
	function automatic logic [wordWidth-1:0] randomInstr(input logic [31:0] r);
		case (r[18:16])
			3'd0, 3'd1: return {opAdd, r[2:0], r[5:3], 3'b000, r[8:6]};
			3'd2: return {opAdd, r[2:0], r[5:3], 1'b1, r[12:8]};
			3'd3: return {opAnd, r[2:0], r[5:3], 3'b000, r[8:6]};
			3'd4: return {opAnd, r[2:0], r[5:3], 1'b1, r[12:8]};
			3'd5, 3'd6: return {opNot, r[2:0], r[5:3], 6'b111111};
			default: return {r[24:23], 2'b10, r[11:0]};
		endcase
	endfunction

	// Sequential LC-3 semantics on the predicted register state
	function automatic resultWord predict(input logic [wordWidth-1:0] instr);
		logic [wordWidth-1:0] a;
		logic [wordWidth-1:0] b;
		logic [wordWidth-1:0] value;
		logic [2:0] nzp;
		a = predRegs[instr[8:6]];
		b = instr[5] ? {{11{instr[4]}}, instr[4:0]} : predRegs[instr[2:0]];
		case (instr[15:12])
			4'b0001: value = a + b;
			4'b0101: value = a & b;
			4'b1001: value = ~a;
			default: return {1'b1, 3'b000, instr[11:9], 16'h0000};
		endcase
		nzp = value[15] ? 3'b100 : ((value == 16'h0000) ? 3'b010 : 3'b001);
		return {1'b0, nzp, instr[11:9], value};
	endfunction

	function automatic string describe(input resultWord r);
		return $sformatf("R%0d=%h nzp=%b illegal=%b", r[18:16], r[15:0], r[21:19], r[22]);
	endfunction

	task automatic reportMismatch(input resultWord expected, input resultWord actual);
		$display("** Error %s: expected %s, actual %s", testName, describe(expected),
			describe(actual));
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic failWith(input string what);
		$display("Failure in %s: %s", testName, what);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	// Wait one rising edge and pick the next outReady value
	task automatic tick();
		@(posedge Clk);
		if (randomReady) begin
			rng = xorshift(rng);
			outReady <= rng[7];
		end else begin
			outReady <= 1'b1;
		end
	endtask

	// Offer one instruction and hold it until accepted
	task automatic issue(input logic [wordWidth-1:0] instr);
		inValid <= 1'b1;
		inInstr <= instr;
		do begin
			tick();
		end while (!inReady);
		inValid <= 1'b0;
	endtask

	// Let every outstanding result leave the pipeline
	task automatic drain();
		@(negedge Clk);
		while (haveExp) begin
			tick();
			@(negedge Clk);
		end
		tick();
	endtask

	assign outFire = outValid && outReady;
	assign latAccept = latencyOn && inValid && inReady;

	// Model follows both handshakes as seen just before the edge
	always @(posedge Clk) begin
		resultWord r;
		if (rst) begin
			expQ.delete();
			for (int i = 0; i < 8; i++) begin
				predRegs[i] = '0;
			end
		end else begin
			if (outFire) begin
				if (expQ.size() > 0) begin
					void'(expQ.pop_front());
				end
			end
			if (inValid && inReady) begin
				r = predict(inInstr);
				if (!r[22]) begin
					predRegs[inInstr[11:9]] = r[15:0];
				end
				expQ.push_back(r);
			end
		end
		haveExp = (expQ.size() > 0);
		if (haveExp) begin
			expHead = expQ[0];
		end
	end

	always @(posedge Clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: run still going after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	end

	assert property (@(negedge Clk) (rst || $fell(rst)) |-> (!outValid && inReady))
		else failWith("outValid high or inReady low around reset");

	assert property (@(negedge Clk) disable iff (rst) outFire |-> haveExp)
		else failWith("output taken with no instruction outstanding");

	assert property (@(negedge Clk) disable iff (rst) (outFire && haveExp) |->
			({outIllegal, outCc, outDest, outData} == expHead))
		else reportMismatch(expHead, {outIllegal, outCc, outDest, outData});

	// A stalled output keeps valid and every field
	assert property (@(negedge Clk) disable iff (rst) $past(outValid && !outReady) |->
			(outValid && $stable({outIllegal, outCc, outDest, outData})))
		else failWith("output changed while outReady was low");

	assert property (@(negedge Clk) disable iff (rst) (latencyOn && inValid) |-> inReady)
		else failWith("independent instruction stalled at the input");

	assert property (@(negedge Clk) disable iff (rst) $past(latAccept, 3) |-> outValid)
		else failWith("outValid missing two edges after acceptance");

	initial begin
		logic [wordWidth-1:0] instr;
		logic [2:0] lastDest;
		inValid = 1'b0;
		inInstr = '0;
		outReady = 1'b1;
		randomReady = 1'b0;
		latencyOn = 1'b0;
		rng = 32'hde1d;
		lastDest = 3'd1;
		testName = "reset";
		tick();
		while (rst) begin
			tick();
		end
		issue(regForm(opAdd, 1, 0, 0));
		drain();

		testName = "arithmetic";
		issue(immForm(opAdd, 2, 0, -1));
		issue(regForm(opAdd, 3, 2, 2));
		issue(immForm(opAnd, 4, 3, 0));
		issue(immForm(opAdd, 5, 0, 15));
		issue(immForm(opAdd, 5, 5, -16));
		issue(regForm(opAnd, 6, 3, 5));
		issue(notForm(7, 0));
		// 16'hffff plus one wraps to zero
		issue(immForm(opAdd, 7, 7, 1));
		issue(notForm(1, 5));
		repeat (100) begin
			rng = xorshift(rng);
			issue(randomInstr(rng));
		end
		drain();

		testName = "dependency";
		repeat (40) begin
			rng = xorshift(rng);
			instr = randomInstr(rng);
			instr[8:6] = lastDest;
			lastDest = instr[11:9];
			issue(instr);
		end
		drain();

		testName = "backpressure";
		randomReady = 1'b1;
		repeat (200) begin
			rng = xorshift(rng);
			issue(randomInstr(rng));
		end
		drain();
		randomReady = 1'b0;

		testName = "illegal";
		issue(immForm(opAdd, 3, 0, 9));
		issue({4'b1111, 3'd3, 9'h025});
		issue(immForm(opAdd, 4, 3, 0));
		issue({4'b0000, 3'd4, 9'h1ff});
		issue(regForm(opAnd, 5, 4, 4));
		drain();

		// Sources stay in R0 to R3 while destinations rotate over R4 to R7
		testName = "latency";
		latencyOn = 1'b1;
		for (int i = 0; i < 24; i++) begin
			rng = xorshift(rng);
			if (rng[0]) begin
				issue(regForm(opAdd, 4 + i % 4, i % 4, (i + 1) % 4));
			end else begin
				issue(immForm(opAnd, 4 + i % 4, i % 4, int'(rng[8:4])));
			end
		end
		latencyOn = 1'b0;
		drain();

		@(negedge Clk);
		if (!outValid) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			failWith("a result is still offered after the last expected one");
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/lc3Pkg.sv
hw/lc3RegFile.sv
hw/lc3Decode.sv
hw/lc3Execute.sv
hw/lc3Result.sv
hw/lc3AluCore.sv
bench/benchClock.sv
bench/lc3AluCoreBench.sv

// ==== Makefile ====
# Verilator build and run for the LC-3 ALU pipeline

VERILATOR ?= verilator
TOP ?= lc3AluCoreBench
DUT_TOP ?= lc3AluCore
FILE_LIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES ?= $(shell grep '^hw/' $(FILE_LIST))

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides the result, the simulator exit code is not trusted alone
run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation gave no result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
